/* build.f */
rtl/cache_pkg.sv
rtl/cache_ifs.sv
rtl/cache_arrays.sv
rtl/word_align.sv
rtl/bus_engine.sv
rtl/cache_ctrl.sv
rtl/l1_data_cache.sv
sim/l1_data_cache_asserts.sv
sim/tb_l1_data_cache.sv

/* rtl/bus_engine.sv */
// memory bus engine
// runs line fills and dirty writebacks on the tagged request and response
// channels, holding each request beat until it is acknowledged
`timescale 1ns/10ps

module bus_engine import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic              clk,
  input  logic              reset,
  xfer_if.engine            xfer,
  output logic              bus_reqcyc,
  input  logic              bus_reqack,
  output logic [WORD_W-1:0] bus_req,
  output bus_tag_t          bus_reqtag,
  input  logic              bus_respcyc,
  input  logic [WORD_W-1:0] bus_resp,
  input  bus_tag_t          bus_resptag,
  output logic              bus_respack
);
  localparam int BEAT_W = $clog2(WORDS_PER_LINE) + 1;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_WB,
    ENG_FILL_REQ,
    ENG_FILL_DATA
  } eng_state_t;

  eng_state_t        state;
  logic [BEAT_W-1:0] beat;
  logic [ADDR_W-1:0] base_addr;
  line_t             wb_buf;
  line_t             fill_buf;
  logic              resp_beat;

  assign base_addr = xfer.line_addr;
  // a fill word arrives
  assign resp_beat = (state == ENG_FILL_DATA) && bus_respcyc && (bus_resptag == MEM_READ);
  assign xfer.fill_line = fill_buf;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state          <= ENG_IDLE;
      beat           <= '0;
      bus_reqcyc     <= 1'b0;
      bus_reqtag     <= NONE;
      bus_respack    <= 1'b0;
      xfer.xfer_done <= 1'b0;
    end else begin
      bus_respack    <= 1'b0;
      xfer.xfer_done <= 1'b0;
      case (state)
        ENG_IDLE: begin
          beat <= '0;
          if (xfer.start_wb) begin
            // address beat first, line kept for the data beats
            bus_reqcyc <= 1'b1;
            bus_req    <= WORD_W'(base_addr);
            bus_reqtag <= MEM_WRITE;
            wb_buf     <= xfer.wb_line;
            state      <= ENG_WB;
          end else if (xfer.start_fill) begin
            bus_reqcyc <= 1'b1;
            bus_req    <= WORD_W'(base_addr);
            bus_reqtag <= MEM_READ;
            state      <= ENG_FILL_REQ;
          end
        end
        ENG_WB: begin
          if (bus_reqack) begin
            if (beat == BEAT_W'(WORDS_PER_LINE)) begin
              // last data word taken
              bus_reqcyc     <= 1'b0;
              bus_reqtag     <= NONE;
              xfer.xfer_done <= 1'b1;
              state          <= ENG_IDLE;
            end else begin
              bus_req <= wb_buf[beat[BEAT_W-2:0]];
              beat    <= beat + 1'b1;
            end
          end
        end
        ENG_FILL_REQ: begin
          if (bus_reqack) begin
            bus_reqcyc <= 1'b0;
            bus_reqtag <= NONE;
            state      <= ENG_FILL_DATA;
          end
        end
        ENG_FILL_DATA: begin
          if (resp_beat) begin
            fill_buf[beat[BEAT_W-2:0]] <= bus_resp;
            bus_respack                <= 1'b1;
            beat                       <= beat + 1'b1;
            if (beat == BEAT_W'(WORDS_PER_LINE - 1)) begin
              xfer.xfer_done <= 1'b1;
              state          <= ENG_IDLE;
            end
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

/* rtl/cache_arrays.sv */
// cache storage arrays
// per way tag, valid, dirty and line data, parallel tag compare,
// victim readout and edge triggered line writes
`timescale 1ns/10ps

module cache_arrays import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int WAYS   = WAYS_DEF,
  parameter int SETS   = SETS_DEF
) (
  input logic    clk,
  array_if.store arr
);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;
  localparam int WAY_W = $clog2(WAYS);

  // storage, indexed [way][set] for tags and data
  logic [TAG_W-1:0] tag_mem   [WAYS][SETS];
  line_t            data_mem  [WAYS][SETS];
  // status bits, one vector of ways per set
  logic [WAYS-1:0]  valid_mem [SETS];
  logic [WAYS-1:0]  dirty_mem [SETS];

  logic [IDX_W-1:0] idx;
  logic [WAYS-1:0]  hit_vec;

  assign idx = arr.lookup_index;

  // compare every way at once
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = valid_mem[idx][w] && (tag_mem[w][idx] == arr.lookup_tag);
    end
  end

  // lowest matching way, tags are unique per set anyway
  always_comb begin
    arr.hit_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) arr.hit_way = WAY_W'(w);
    end
  end

  assign arr.hit       = |hit_vec;
  assign arr.hit_line  = data_mem[arr.hit_way][idx];
  assign arr.set_valid = valid_mem[idx];

  // state of the way the controller wants to replace
  assign arr.victim_valid = valid_mem[idx][arr.victim_way];
  assign arr.victim_dirty = dirty_mem[idx][arr.victim_way];
  assign arr.victim_tag   = tag_mem[arr.victim_way][idx];
  assign arr.victim_line  = data_mem[arr.victim_way][idx];

  always_ff @(posedge clk) begin
    if (arr.clear_en) begin
      // sweep step, drop the whole set
      valid_mem[idx] <= '0;
      dirty_mem[idx] <= '0;
    end else if (arr.wr_en) begin
      valid_mem[idx][arr.wr_way] <= 1'b1;
      dirty_mem[idx][arr.wr_way] <= arr.wr_dirty;
      tag_mem[arr.wr_way][idx]   <= arr.wr_tag;
      data_mem[arr.wr_way][idx]  <= arr.wr_line;
    end
  end

endmodule

/* rtl/cache_ctrl.sv */
// cache access controller
// sequences lookup, writeback, fill and update for one cpu access,
// picks victims and runs the valid clear sweep after reset
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int WAYS   = WAYS_DEF,
  parameter int SETS   = SETS_DEF
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                req,
  input  logic                write,
  input  logic [ADDR_W-1:0]   address,
  input  logic [WORD_W-1:0]   wdata,
  input  mem_op_t             mem_op,
  output logic                busy,
  output logic                done,
  output logic [WORD_W-1:0]   rdata,
  array_if.ctrl               arr,
  xfer_if.ctrl                xfer,
  input  logic [WORD_W-1:0]   load_value,
  input  line_t               merged_line,
  output line_t               sel_line,
  output logic [OFFSET_W-1:0] sel_offset,
  output mem_op_t             sel_op,
  output logic [WORD_W-1:0]   sel_wdata
);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;
  localparam int WAY_W = $clog2(WAYS);

  ctrl_state_t       state;
  // captured request
  logic              write_q;
  logic [ADDR_W-1:0] addr_q;
  logic [WORD_W-1:0] wdata_q;
  mem_op_t           op_q;
  logic [IDX_W-1:0]  req_idx;
  logic [TAG_W-1:0]  req_tag;
  // way bookkeeping
  logic              hit_q;
  logic [WAY_W-1:0]  way_q;
  logic [WAY_W-1:0]  rr_way;
  logic [WAY_W-1:0]  pick_way;
  // reset sweep
  logic              clearing;
  logic [IDX_W-1:0]  sweep_idx;

  assign req_idx = addr_q[OFFSET_W +: IDX_W];
  assign req_tag = addr_q[ADDR_W-1 -: TAG_W];

  always_ff @(posedge clk) begin
    if (state == IDLE && req && !clearing) begin
      write_q <= write;
      addr_q  <= address;
      wdata_q <= wdata;
      op_q    <= mem_op;
    end
  end

  // first empty way wins, otherwise round robin
  always_comb begin
    pick_way = rr_way;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!arr.set_valid[w]) pick_way = WAY_W'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state           <= IDLE;
      clearing        <= 1'b1;
      sweep_idx       <= '0;
      rr_way          <= '0;
      hit_q           <= 1'b0;
      way_q           <= '0;
      xfer.start_fill <= 1'b0;
      xfer.start_wb   <= 1'b0;
    end else begin
      xfer.start_fill <= 1'b0;
      xfer.start_wb   <= 1'b0;
      // one set per cycle
      if (clearing) begin
        sweep_idx <= sweep_idx + 1'b1;
        if (sweep_idx == IDX_W'(SETS - 1)) clearing <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (req && !clearing) state <= LOOKUP;
        end
        LOOKUP: begin
          hit_q <= arr.hit;
          if (arr.hit) begin
            way_q <= arr.hit_way;
            state <= UPDATE;
          end else begin
            way_q <= pick_way;
            if (arr.victim_valid && arr.victim_dirty) begin
              // old line goes out before the fill
              xfer.start_wb  <= 1'b1;
              xfer.line_addr <= {arr.victim_tag, req_idx, {OFFSET_W{1'b0}}};
              state          <= WRITEBACK;
            end else begin
              xfer.start_fill <= 1'b1;
              xfer.line_addr  <= {req_tag, req_idx, {OFFSET_W{1'b0}}};
              state           <= FILL;
            end
          end
        end
        WRITEBACK: begin
          if (xfer.xfer_done) begin
            xfer.start_fill <= 1'b1;
            xfer.line_addr  <= {req_tag, req_idx, {OFFSET_W{1'b0}}};
            state           <= FILL;
          end
        end
        FILL: begin
          if (xfer.xfer_done) begin
            rr_way <= rr_way + 1'b1;
            state  <= UPDATE;
          end
        end
        UPDATE:  state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // sweep borrows the index port
  assign arr.lookup_index = clearing ? sweep_idx : req_idx;
  assign arr.lookup_tag   = req_tag;
  assign arr.clear_en     = clearing;
  assign arr.victim_way   = (state == LOOKUP) ? pick_way : way_q;

  // load hits leave the line alone
  assign arr.wr_en    = (state == UPDATE) && (write_q || !hit_q);
  assign arr.wr_way   = way_q;
  assign arr.wr_tag   = req_tag;
  assign arr.wr_dirty = write_q;
  assign arr.wr_line  = merged_line;

  assign xfer.wb_line = arr.victim_line;

  // alignment works on the hit line or the freshly filled one
  assign sel_line   = hit_q ? arr.hit_line : xfer.fill_line;
  assign sel_offset = addr_q[OFFSET_W-1:0];
  assign sel_op     = op_q;
  assign sel_wdata  = wdata_q;

  assign busy  = clearing || (state != IDLE);
  assign done  = (state == UPDATE);
  assign rdata = load_value;

endmodule

/* rtl/cache_ifs.sv */
// internal cache interfaces
// array_if carries lookup and line writes between controller and storage,
// xfer_if carries fill and writeback requests to the bus engine
`timescale 1ns/10ps

interface array_if import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int WAYS   = WAYS_DEF,
  parameter int SETS   = SETS_DEF
) ();
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - OFFSET_W;
  localparam int WAY_W = $clog2(WAYS);

  // lookup side
  logic [IDX_W-1:0] lookup_index;
  logic [TAG_W-1:0] lookup_tag;
  logic             hit;
  logic [WAY_W-1:0] hit_way;
  line_t            hit_line;
  logic [WAYS-1:0]  set_valid;

  // victim state for the named way
  logic [WAY_W-1:0] victim_way;
  logic             victim_valid;
  logic             victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  line_t            victim_line;

  // write side, applied at the edge
  logic             clear_en;
  logic             wr_en;
  logic [WAY_W-1:0] wr_way;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_dirty;
  line_t            wr_line;

  modport ctrl (
    output lookup_index, lookup_tag, victim_way,
    output clear_en, wr_en, wr_way, wr_tag, wr_dirty, wr_line,
    input  hit, hit_way, hit_line, set_valid,
    input  victim_valid, victim_dirty, victim_tag, victim_line
  );

  modport store (
    input  lookup_index, lookup_tag, victim_way,
    input  clear_en, wr_en, wr_way, wr_tag, wr_dirty, wr_line,
    output hit, hit_way, hit_line, set_valid,
    output victim_valid, victim_dirty, victim_tag, victim_line
  );
endinterface

interface xfer_if import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF
) ();
  // start pulses, only while the engine is idle
  logic              start_fill;
  logic              start_wb;
  // line aligned address for either transfer
  logic [ADDR_W-1:0] line_addr;
  line_t             wb_line;
  line_t             fill_line;
  logic              xfer_done;

  modport ctrl (
    output start_fill, start_wb, line_addr, wb_line,
    input  fill_line, xfer_done
  );

  modport engine (
    input  start_fill, start_wb, line_addr, wb_line,
    output fill_line, xfer_done
  );
endinterface

/* rtl/cache_pkg.sv */
// l1 data cache shared definitions
// geometry defaults, line type, memory ops, bus tags and controller states

package cache_pkg;

  // default geometry, 4 ways x 32 sets x 64 B = 8 KB
  parameter int ADDR_W_DEF = 64;
  parameter int WAYS_DEF   = 4;
  parameter int SETS_DEF   = 32;

  // word and line shape
  parameter int WORD_W         = 64;
  parameter int WORDS_PER_LINE = 8;
  parameter int OFFSET_W       = 6;

  // word 0 sits in the low bits
  typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

  // loads first, then stores
  typedef enum logic [3:0] {
    LD, LW, LH, LB,
    LWU, LHU, LBU,
    SD, SW, SH, SB
  } mem_op_t;

  // tag carried on both bus channels
  typedef enum logic [1:0] {
    NONE      = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } bus_tag_t;

  // access sequencing in the controller
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    FILL,
    UPDATE
  } ctrl_state_t;

endpackage

/* rtl/l1_data_cache.sv */
// l1 data cache top
// 4 way set associative, write back, write allocate data cache with a
// cpu request port and a tagged memory bus port
`timescale 1ns/10ps

module l1_data_cache import cache_pkg::*; #(
  parameter int ADDR_W = ADDR_W_DEF,
  parameter int WAYS   = WAYS_DEF,
  parameter int SETS   = SETS_DEF
) (
  input  logic              clk,
  input  logic              reset,
  // cpu side
  input  logic              req,
  input  logic              write,
  input  logic [ADDR_W-1:0] address,
  input  logic [WORD_W-1:0] wdata,
  input  mem_op_t           mem_op,
  output logic              busy,
  output logic              done,
  output logic [WORD_W-1:0] rdata,
  // memory bus
  output logic              bus_reqcyc,
  input  logic              bus_reqack,
  output logic [WORD_W-1:0] bus_req,
  output bus_tag_t          bus_reqtag,
  input  logic              bus_respcyc,
  input  logic [WORD_W-1:0] bus_resp,
  input  bus_tag_t          bus_resptag,
  output logic              bus_respack
);
  array_if #(.ADDR_W(ADDR_W), .WAYS(WAYS), .SETS(SETS)) arr_bus ();
  xfer_if  #(.ADDR_W(ADDR_W)) xfer_bus ();

  // alignment path between controller and word_align
  line_t               sel_line;
  line_t               merged_line;
  logic [OFFSET_W-1:0] sel_offset;
  mem_op_t             sel_op;
  logic [WORD_W-1:0]   sel_wdata;
  logic [WORD_W-1:0]   load_value;

  cache_ctrl #(.ADDR_W(ADDR_W), .WAYS(WAYS), .SETS(SETS)) ctrl0 (
    .clk(clk), .reset(reset),
    .req(req), .write(write), .address(address), .wdata(wdata), .mem_op(mem_op),
    .busy(busy), .done(done), .rdata(rdata),
    .arr(arr_bus.ctrl), .xfer(xfer_bus.ctrl),
    .load_value(load_value), .merged_line(merged_line),
    .sel_line(sel_line), .sel_offset(sel_offset), .sel_op(sel_op), .sel_wdata(sel_wdata)
  );

  cache_arrays #(.ADDR_W(ADDR_W), .WAYS(WAYS), .SETS(SETS)) arrays0 (
    .clk(clk), .arr(arr_bus.store)
  );

  word_align align0 (
    .line(sel_line), .offset(sel_offset), .op(sel_op), .wdata(sel_wdata),
    .load_value(load_value), .merged_line(merged_line)
  );

  bus_engine #(.ADDR_W(ADDR_W)) engine0 (
    .clk(clk), .reset(reset), .xfer(xfer_bus.engine),
    .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc), .bus_resp(bus_resp),
    .bus_resptag(bus_resptag), .bus_respack(bus_respack)
  );

endmodule

/* rtl/word_align.sv */
// load and store alignment
// picks the addressed doubleword, word, half or byte out of a line and
// extends it, and merges store data into a copy of the line
`timescale 1ns/10ps

module word_align import cache_pkg::*; (
  input  line_t               line,
  input  logic [OFFSET_W-1:0] offset,
  input  mem_op_t             op,
  input  logic [WORD_W-1:0]   wdata,
  output logic [WORD_W-1:0]   load_value,
  output line_t               merged_line
);
  localparam int LINE_BYTES = WORDS_PER_LINE * WORD_W / 8;

  logic [WORD_W-1:0]            word_sel;
  logic [WORD_W-1:0]            shifted;
  logic [3:0]                   store_bytes;
  logic [LINE_BYTES-1:0][7:0]   line_bytes;
  logic [LINE_BYTES-1:0][7:0]   merged_bytes;
  logic [OFFSET_W-1:0]          pos;

  // doubleword holding the access, then move the field down to bit 0
  assign word_sel = line[offset[OFFSET_W-1:3]];
  assign shifted  = word_sel >> {offset[2:0], 3'b000};

  always_comb begin
    case (op)
      LD:      load_value = shifted;
      LW:      load_value = {{32{shifted[31]}}, shifted[31:0]};
      LH:      load_value = {{48{shifted[15]}}, shifted[15:0]};
      LB:      load_value = {{56{shifted[7]}}, shifted[7:0]};
      LWU:     load_value = {32'b0, shifted[31:0]};
      LHU:     load_value = {48'b0, shifted[15:0]};
      LBU:     load_value = {56'b0, shifted[7:0]};
      default: load_value = '0;
    endcase
  end

  // bytes written per store, zero for loads
  always_comb begin
    case (op)
      SD:      store_bytes = 4'd8;
      SW:      store_bytes = 4'd4;
      SH:      store_bytes = 4'd2;
      SB:      store_bytes = 4'd1;
      default: store_bytes = 4'd0;
    endcase
  end

  assign line_bytes = line;

  // low store bytes land at offset upward, the rest of the line is kept
  always_comb begin
    merged_bytes = line_bytes;
    pos          = offset;
    for (int i = 0; i < 8; i++) begin
      if (i < int'(store_bytes)) merged_bytes[pos] = wdata[8*i +: 8];
      pos = pos + OFFSET_W'(1);
    end
  end

  assign merged_line = merged_bytes;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_l1_data_cache \
  -f build.f -o tb_l1_data_cache
out=$(./obj_dir/tb_l1_data_cache)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

/* sim/l1_data_cache_asserts.sv */
// protocol checker for the l1 data cache
// request beats hold under back pressure, done is a single cycle pulse,
// respack only follows an accepted fill beat
`timescale 1ns/10ps

module l1_data_cache_asserts import cache_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              done,
  input logic              bus_reqcyc,
  input logic              bus_reqack,
  input logic [WORD_W-1:0] bus_req,
  input bus_tag_t          bus_reqtag,
  input logic              bus_respcyc,
  input bus_tag_t          bus_resptag,
  input logic              bus_respack
);

  // beat waits unchanged until the ack
  property req_held;
    @(posedge clk) disable iff (!reset)
      (bus_reqcyc && !bus_reqack) |=>
        (bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag));
  endproperty

  property done_single;
    @(posedge clk) disable iff (!reset) done |=> !done;
  endproperty

  // ack one cycle behind a taken fill word
  property respack_after_beat;
    @(posedge clk) disable iff (!reset)
      bus_respack |-> $past(bus_respcyc && (bus_resptag == MEM_READ));
  endproperty

  req_held_a: assert property (req_held)
    else $error("request beat changed or dropped before its ack");
  done_single_a: assert property (done_single)
    else $error("done stayed high for more than one cycle");
  respack_a: assert property (respack_after_beat)
    else $error("bus_respack without an accepted response beat");

endmodule

bind l1_data_cache l1_data_cache_asserts asserts0 (
  .clk(clk), .reset(reset), .done(done),
  .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
  .bus_req(bus_req), .bus_reqtag(bus_reqtag),
  .bus_respcyc(bus_respcyc), .bus_resptag(bus_resptag),
  .bus_respack(bus_respack)
);

/* sim/tb_l1_data_cache.sv */
// testbench for the l1 data cache
// memory model with bus responder, shadow memory with a load reference,
// directed and random load/store tests
`timescale 1ns/10ps

module tb_l1_data_cache import cache_pkg::*; ();
  localparam int          CLK_PERIOD      = 40;
  localparam int          RANDOM_ACCESSES = 400;
  // worst access is a full writeback plus fill with the slowest acks
  localparam int          ACCESS_CYCLES   = 80;
  localparam int          WATCHDOG_CYCLES = (RANDOM_ACCESSES + 100) * ACCESS_CYCLES + 200;
  localparam logic [63:0] PATTERN_MUL     = 64'h9e37_79b9_7f4a_7c15;
  localparam logic [15:0] LFSR_TAPS       = 16'hb400;

  logic        clk;
  logic        reset;
  logic        req;
  logic        write;
  logic [63:0] address;
  logic [63:0] wdata;
  mem_op_t     mem_op;
  logic        busy;
  logic        done;
  logic [63:0] rdata;
  logic        bus_reqcyc;
  logic        bus_reqack;
  logic [63:0] bus_req;
  bus_tag_t    bus_reqtag;
  logic        bus_respcyc;
  logic [63:0] bus_resp;
  bus_tag_t    bus_resptag;
  logic        bus_respack;

  // memory behind the bus and the cpu view of memory
  logic [63:0] mem_words    [logic [63:0]];
  logic [63:0] shadow_words [logic [63:0]];
  // stream 0 drives stimulus and stream 1 ack delays
  logic [15:0] lfsr_state [2] = '{16'd44845, 16'd44845};

  // access in flight for the compare process
  mem_op_t     cur_op;
  logic [63:0] cur_addr;
  logic [63:0] cur_wdata;
  int          tests_run = 0;
  int          checks = 0;
  int          errors = 0;
  int          fill_count = 0;
  int          wb_count = 0;
  logic [63:0] last_fill_addr;

  l1_data_cache dut0 (
    .clk(clk), .reset(reset),
    .req(req), .write(write), .address(address), .wdata(wdata), .mem_op(mem_op),
    .busy(busy), .done(done), .rdata(rdata),
    .bus_reqcyc(bus_reqcyc), .bus_reqack(bus_reqack),
    .bus_req(bus_req), .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc), .bus_resp(bus_resp),
    .bus_resptag(bus_resptag), .bus_respack(bus_respack)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [63:0] rand_bits(input int stream, input int n);
    logic [63:0] v;
    logic        out_bit;
    v = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr_state[stream][0];
      lfsr_state[stream] = lfsr_state[stream] >> 1;
      if (out_bit) lfsr_state[stream] = lfsr_state[stream] ^ LFSR_TAPS;
      v[i] = out_bit;
    end
    return v;
  endfunction

  // untouched words hold address times an odd constant
  function automatic logic [63:0] mem_word(input logic [63:0] a);
    return mem_words.exists(a) ? mem_words[a] : a * PATTERN_MUL;
  endfunction

  function automatic logic [63:0] shadow_word(input logic [63:0] a);
    return shadow_words.exists(a) ? shadow_words[a] : a * PATTERN_MUL;
  endfunction

  function automatic logic [7:0] shadow_byte(input logic [63:0] a);
    logic [63:0] w;
    w = shadow_word({a[63:3], 3'b000});
    return w[8*a[2:0] +: 8];
  endfunction

  function automatic int op_size(input mem_op_t op);
    case (op)
      LD, SD:      return 8;
      LW, LWU, SW: return 4;
      LH, LHU, SH: return 2;
      default:     return 1;
    endcase
  endfunction

  function automatic bit op_is_store(input mem_op_t op);
    return op inside {SD, SW, SH, SB};
  endfunction

  // reference load built byte by byte from the shadow and then extended
  function automatic logic [63:0] expected_load(input mem_op_t op, input logic [63:0] a);
    int          n;
    logic [63:0] v;
    n = op_size(op);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = shadow_byte(a + 64'(i));
    if ((op inside {LW, LH, LB}) && v[8*n-1]) v = v | ~((64'd1 << (8 * n)) - 64'd1);
    return v;
  endfunction

  task automatic shadow_store(input mem_op_t op, input logic [63:0] a, input logic [63:0] d);
    logic [63:0] ba;
    logic [63:0] w;
    for (int i = 0; i < op_size(op); i++) begin
      ba = a + 64'(i);
      w  = shadow_word({ba[63:3], 3'b000});
      w[8*ba[2:0] +: 8] = d[8*i +: 8];
      shadow_words[{ba[63:3], 3'b000}] = w;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input string what, input bit cond);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errors == err_before) ? "ok" : "failed", errors - err_before);
  endtask

  task automatic end_run();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // starts and ends 2 ns after an edge with the cache idle
  task automatic access(input mem_op_t op, input logic [63:0] a, input logic [63:0] d,
                        output int latency);
    int n;
    cur_op    = op;
    cur_addr  = a;
    cur_wdata = d;
    req       = 1'b1;
    write     = op_is_store(op);
    address   = a;
    wdata     = d;
    mem_op    = op;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (done !== 1'b1);
    // first negedge falls before the sampling edge
    latency = n - 1;
    @(posedge clk);
    #2;
    req = 1'b0;
  endtask

  // one request beat acked after 0 to 3 cycles
  task automatic take_beat(output logic [63:0] value, output bus_tag_t tag);
    int wait_cycles;
    wait_cycles = int'(rand_bits(1, 2));
    repeat (wait_cycles) @(posedge clk);
    @(posedge clk);
    #2;
    bus_reqack = 1'b1;
    @(negedge clk);
    check_true("bus_reqcyc dropped before its beat was acknowledged", bus_reqcyc === 1'b1);
    value = bus_req;
    tag   = bus_reqtag;
    @(posedge clk);
    #2;
    bus_reqack = 1'b0;
  endtask

  task automatic send_fill(input logic [63:0] line_addr);
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      bus_respcyc = 1'b1;
      bus_resptag = MEM_READ;
      bus_resp    = mem_word(line_addr + 64'(8 * i));
      @(posedge clk);
      #2;
      // each accepted word is acknowledged in the following cycle
      check_value("bus_respack", 64'(bus_respack), 64'd1);
    end
    bus_respcyc = 1'b0;
    bus_resptag = NONE;
    bus_resp    = '0;
  endtask

  // dirty line must equal the cpu view of it
  task automatic collect_writeback(input logic [63:0] line_addr);
    logic [63:0] v;
    bus_tag_t    t;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      take_beat(v, t);
      check_value("bus_reqtag", 64'(t), 64'(MEM_WRITE));
      check_value("bus_req writeback data", v, shadow_word(line_addr + 64'(8 * i)));
      mem_words[line_addr + 64'(8 * i)] = v;
    end
  endtask

  initial begin : bus_responder
    logic [63:0] line_addr;
    bus_tag_t    tag;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp    = '0;
    bus_resptag = NONE;
    forever begin
      @(negedge clk);
      if (bus_reqcyc === 1'b1) begin
        take_beat(line_addr, tag);
        check_value("bus_req line offset", 64'(line_addr[5:0]), 64'd0);
        if (tag == MEM_READ) begin
          fill_count++;
          last_fill_addr = line_addr;
          send_fill(line_addr);
        end else if (tag == MEM_WRITE) begin
          wb_count++;
          collect_writeback(line_addr);
        end else begin
          check_true("request beat carried no bus tag", 1'b0);
        end
      end
    end
  end

  // loads go against the reference and stores into the shadow
  always @(negedge clk) begin
    if (done === 1'b1) begin
      if (op_is_store(cur_op)) shadow_store(cur_op, cur_addr, cur_wdata);
      else check_value("rdata", rdata, expected_load(cur_op, cur_addr));
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    errors++;
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    end_run();
  end

  initial begin : stimulus
    int          lat;
    int          err0;
    int          fills0;
    int          wbs0;
    int          sweep_cycles;
    mem_op_t     op;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] base;
    reset   = 1'b0;
    req     = 1'b0;
    write   = 1'b0;
    address = '0;
    wdata   = '0;
    mem_op  = LD;
    repeat (10) @(posedge clk);
    #2;

    // reset state and first fill
    err0 = errors;
    check_value("done", 64'(done), 64'd0);
    check_value("bus_reqcyc", 64'(bus_reqcyc), 64'd0);
    check_value("bus_respack", 64'(bus_respack), 64'd0);
    reset = 1'b1;
    // valid sweep keeps busy up for one cycle per set
    sweep_cycles = 0;
    do begin
      @(posedge clk);
      #2;
      sweep_cycles++;
    end while (busy !== 1'b0);
    check_value("busy sweep cycles", 64'(sweep_cycles), 64'(SETS_DEF));
    fills0 = fill_count;
    wbs0   = wb_count;
    access(LD, 64'h1008, '0, lat);
    check_value("fill request count", 64'(fill_count - fills0), 64'd1);
    check_value("bus_req fill address", last_fill_addr, 64'h1000);
    check_value("writeback count", 64'(wb_count - wbs0), 64'd0);
    report_test("reset and first fill", err0);

    // every load op at aligned offsets on hits
    err0 = errors;
    for (int i = 0; i < 7; i++) begin
      for (int k = 0; k < 4; k++) begin
        op = mem_op_t'(4'(i));
        a  = 64'h1000 + 64'((k * 21 + i * 11) % 64);
        a  = a & ~64'(op_size(op) - 1);
        access(op, a, '0, lat);
        check_value("hit latency", 64'(lat), 64'd2);
      end
    end
    report_test("load extension on hits", err0);

    // each store width followed by the bytes around it
    err0 = errors;
    access(SD, 64'h1010, 64'hf0e1_d2c3_b4a5_9687, lat);
    access(LD, 64'h1008, '0, lat);
    access(LD, 64'h1010, '0, lat);
    access(LD, 64'h1018, '0, lat);
    access(SW, 64'h1024, 64'h1111_2222_8765_4321, lat);
    access(LD, 64'h1020, '0, lat);
    access(LW, 64'h1024, '0, lat);
    access(LWU, 64'h1020, '0, lat);
    access(SH, 64'h1032, 64'h3333_4444_5555_beef, lat);
    access(LD, 64'h1030, '0, lat);
    access(LH, 64'h1032, '0, lat);
    access(LHU, 64'h1030, '0, lat);
    access(SB, 64'h103d, 64'h6666_7777_8888_99a5, lat);
    access(LD, 64'h1038, '0, lat);
    access(LB, 64'h103d, '0, lat);
    access(LBU, 64'h103c, '0, lat);
    // store miss fills first, then merges
    access(SD, 64'h5040, 64'h0123_4567_89ab_cdef, lat);
    access(LD, 64'h5040, '0, lat);
    access(LD, 64'h5048, '0, lat);
    report_test("stores of every width", err0);

    // five dirty lines 2 KB apart in set 5
    err0 = errors;
    wbs0 = wb_count;
    for (int k = 0; k < 5; k++) begin
      base = 64'h20140 + 64'(k * 'h800);
      access(SD, base, 64'hc0de_0000_0000_0000 + 64'(k), lat);
      access(SD, base + 64'h38, 64'h8000_0000_0000_0000 | 64'(k * 3), lat);
    end
    for (int k = 0; k < 5; k++) begin
      base = 64'h20140 + 64'(k * 'h800);
      access(LD, base, '0, lat);
      access(LD, base + 64'h38, '0, lat);
      access(LD, base + 64'h8, '0, lat);
    end
    check_true("no writeback seen for five dirty lines in one set", wb_count > wbs0);
    report_test("dirty writeback", err0);

    // random loads and stores over 16 tags in 4 sets
    err0 = errors;
    for (int i = 0; i < RANDOM_ACCESSES; i++) begin
      op = mem_op_t'(4'(rand_bits(0, 4) % 11));
      a  = 64'h30000 | (rand_bits(0, 4) << 11);
      a  = a | (rand_bits(0, 2) << 6);
      a  = a | rand_bits(0, 6);
      a  = a & ~64'(op_size(op) - 1);
      d  = op_is_store(op) ? rand_bits(0, 64) : '0;
      access(op, a, d, lat);
    end
    report_test("random mixed traffic", err0);

    end_run();
  end

endmodule
